/* Makefile */
# Verilator build and run for the AXI-lite fan-out bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_axil_single
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
+incdir+include
logic/axil_bus_pkg.sv
logic/axil_port_pkg.sv
logic/aw_skid.sv
logic/resp_fifo.sv
logic/write_path.sv
logic/read_path.sv
logic/axil_single_top.sv
sim/tb_periph_bank.sv
sim/tb_axil_single.sv

/* include/axil_single_params.svh */
`ifndef AXIL_SINGLE_PARAMS_SVH
`define AXIL_SINGLE_PARAMS_SVH

// Host data bus width in bits
`define AXIL_DW 32

// Number of single-register peripherals behind the bridge
`define AXIL_NS 12

// Log2 of the return FIFO depth, also the credit limit
`define AXIL_LGFLEN 3

// Byte offset bits below the word index
`define AXIL_ADDR_LSBS 2
`define AXIL_IDXW 4
`define AXIL_AW (`AXIL_IDXW + `AXIL_ADDR_LSBS)

// AXI response encodings
`define AXIL_RESP_OKAY 2'b00
`define AXIL_RESP_EXOKAY 2'b01
`define AXIL_RESP_SLVERR 2'b10
`define AXIL_RESP_DECERR 2'b11

`endif

/* logic/aw_skid.sv */
`timescale 1ns/1ps

module aw_skid
	import axil_bus_pkg::*;
(
	input  logic       S_AXI_ACLK,
	input  logic       S_AXI_ARESETN,
	// Upstream (host AW channel)
	input  logic       i_valid,
	output logic       o_ready,
	input  axil_addr_t i_data,
	// Downstream (write path)
	output logic       o_valid,
	input  logic       i_ready,
	output axil_addr_t o_data
);

	// One parked address, the other rides the bypass
	logic       r_valid;
	axil_addr_t r_data;

	// Park an address when downstream stalls on it
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Capture whatever is offered while the slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	// Ready comes straight from a flop
	assign o_ready = !r_valid;

	// Empty buffer passes through in zero cycles
	assign o_valid = i_valid || r_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

/* logic/axil_bus_pkg.sv */
`include "axil_single_params.svh"

package axil_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Host side AXI-lite types
	////////////////////////////////////////////////////////////////////////////

	// BRESP / RRESP
	// DECERR is what the bridge returns for an unmapped index
	typedef enum logic [1:0]
	{
		OKAY   = `AXIL_RESP_OKAY,
		EXOKAY = `AXIL_RESP_EXOKAY,
		SLVERR = `AXIL_RESP_SLVERR,
		DECERR = `AXIL_RESP_DECERR
	} axil_resp_t;

	// AW or AR request
	typedef struct packed
	{
		logic [`AXIL_AW-1:0] addr;
		logic [2:0]          prot;
	} axil_addr_t;

	// W beat, 36 bits
	typedef struct packed
	{
		logic [`AXIL_DW-1:0]   data;
		logic [`AXIL_DW/8-1:0] strb;
	} axil_wbeat_t;

	// R beat, 34 bits
	typedef struct packed
	{
		logic [`AXIL_DW-1:0] data;
		axil_resp_t          resp;
	} axil_rbeat_t;

endpackage

/* logic/axil_port_pkg.sv */
`include "axil_single_params.svh"

package axil_port_pkg;
	import axil_bus_pkg::*;

	// Peripheral index and one-hot select
	typedef logic [`AXIL_IDXW-1:0] slv_idx_t;
	typedef logic [`AXIL_NS-1:0]   slv_sel_t;

	// Per-peripheral response and data arrays
	typedef logic [`AXIL_NS-1:0][1:0]          slv_resp_bus_t;
	typedef logic [`AXIL_NS-1:0][`AXIL_DW-1:0] slv_data_bus_t;

	// Write strobe bundle, data and strobe shared by all peripherals
	typedef struct packed
	{
		slv_sel_t    sel;
		logic [2:0]  prot;
		axil_wbeat_t w;
	} slv_wr_req_t;

	// Read strobe bundle
	typedef struct packed
	{
		slv_sel_t   sel;
		logic [2:0] prot;
	} slv_rd_req_t;

	// Everything the peripherals hand back
	typedef struct packed
	{
		slv_resp_bus_t bresp;
		slv_data_bus_t rdata;
		slv_resp_bus_t rresp;
	} slv_rsp_t;

	// Word index out of a byte address
	function automatic slv_idx_t slv_index(input axil_addr_t a);
		return a.addr[`AXIL_AW-1:`AXIL_ADDR_LSBS];
	endfunction

	// Index maps to a real peripheral
	function automatic logic slv_in_range(input slv_idx_t idx);
		return (idx < `AXIL_NS);
	endfunction

	// One-hot select, zero for an unmapped index
	function automatic slv_sel_t slv_decode(input slv_idx_t idx);
		slv_sel_t sel;
		sel = '0;
		if (slv_in_range(idx))
			sel[idx] = 1'b1;
		return sel;
	endfunction

endpackage

/* logic/axil_single_top.sv */
`timescale 1ns/1ps
`include "axil_single_params.svh"

module axil_single_top
	import axil_bus_pkg::*, axil_port_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	// AW
	input  logic        i_awvalid,
	output logic        o_awready,
	input  axil_addr_t  i_aw,
	// W
	input  logic        i_wvalid,
	output logic        o_wready,
	input  axil_wbeat_t i_w,
	// B
	output logic        o_bvalid,
	input  logic        i_bready,
	output axil_resp_t  o_bresp,
	// AR
	input  logic        i_arvalid,
	output logic        o_arready,
	input  axil_addr_t  i_ar,
	// R
	output logic        o_rvalid,
	input  logic        i_rready,
	output axil_rbeat_t o_r,
	// Peripherals
	output slv_wr_req_t o_wr_req,
	output slv_rd_req_t o_rd_req,
	input  slv_rsp_t    i_rsp
);

	logic        skid_valid;
	logic        skid_ready;
	axil_addr_t  skid_aw;
	logic        b_push;
	logic        b_empty;
	logic        b_pop;
	axil_resp_t  b_resp;
	logic        r_push;
	logic        r_empty;
	logic        r_pop;
	axil_rbeat_t r_beat;

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	aw_skid u_awskid (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_awvalid),
		.o_ready       (o_awready),
		.i_data        (i_aw),
		.o_valid       (skid_valid),
		.i_ready       (skid_ready),
		.o_data        (skid_aw)
	);

	write_path u_wpath (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_aw_valid    (skid_valid),
		.o_aw_ready    (skid_ready),
		.i_aw          (skid_aw),
		.i_wvalid      (i_wvalid),
		.o_wready      (o_wready),
		.i_w           (i_w),
		.i_bpop        (b_pop),
		.o_wr_req      (o_wr_req),
		.i_bresp_bus   (i_rsp.bresp),
		.o_push        (b_push),
		.o_bresp       (b_resp)
	);

	resp_fifo #(.payload_t(axil_resp_t), .LGFLEN(`AXIL_LGFLEN)) u_bfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (b_push),
		.i_data        (b_resp),
		.i_pop         (b_pop),
		.o_data        (o_bresp),
		.o_empty       (b_empty)
	);

	// Host sees B whenever the queue holds something
	assign o_bvalid = !b_empty;
	assign b_pop    = o_bvalid && i_bready;

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	read_path u_rpath (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_arvalid     (i_arvalid),
		.o_arready     (o_arready),
		.i_ar          (i_ar),
		.i_rpop        (r_pop),
		.o_rd_req      (o_rd_req),
		.i_rdata_bus   (i_rsp.rdata),
		.i_rresp_bus   (i_rsp.rresp),
		.o_push        (r_push),
		.o_r           (r_beat)
	);

	resp_fifo #(.payload_t(axil_rbeat_t), .LGFLEN(`AXIL_LGFLEN)) u_rfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (r_push),
		.i_data        (r_beat),
		.i_pop         (r_pop),
		.o_data        (o_r),
		.o_empty       (r_empty)
	);

	assign o_rvalid = !r_empty;
	assign r_pop    = o_rvalid && i_rready;

endmodule

/* logic/read_path.sv */
`timescale 1ns/1ps
`include "axil_single_params.svh"

module read_path
	import axil_bus_pkg::*, axil_port_pkg::*;
(
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	// Host AR channel
	input  logic          i_arvalid,
	output logic          o_arready,
	input  axil_addr_t    i_ar,
	// R FIFO pop, returns a credit
	input  logic          i_rpop,
	// Peripheral side
	output slv_rd_req_t   o_rd_req,
	input  slv_data_bus_t i_rdata_bus,
	input  slv_resp_bus_t i_rresp_bus,
	// R FIFO push
	output logic          o_push,
	output axil_rbeat_t   o_r
);

	localparam int DEPTH = 1 << `AXIL_LGFLEN;
	localparam int CW    = `AXIL_LGFLEN + 1;

	slv_sel_t      r_sel;
	logic [2:0]    r_prot;
	logic          r_rwait;
	logic          r_rvalid;
	logic          r_push;
	slv_idx_t      r_ridx;
	slv_idx_t      r_lidx;
	axil_rbeat_t   r_beat;
	logic [CW-1:0] r_count;
	logic          w_full;
	logic          ar_fire;
	slv_idx_t      ar_idx;

	assign ar_idx    = slv_index(i_ar);
	assign w_full    = (r_count == CW'(DEPTH));
	assign o_arready = !w_full;
	assign ar_fire   = i_arvalid && o_arready;

	////////////////////////////////////////////////////////////////////////////
	// Strobe and pipeline control
	////////////////////////////////////////////////////////////////////////////

	// Strobe is a registered one-cycle pulse
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_sel    <= '0;
			r_rwait  <= 1'b0;
			r_rvalid <= 1'b0;
			r_push   <= 1'b0;
		end
		else
		begin
			r_sel    <= ar_fire ? slv_decode(ar_idx) : '0;
			r_rwait  <= ar_fire;
			r_rvalid <= r_rwait;
			r_push   <= r_rvalid;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_fire)
		begin
			r_prot <= i_ar.prot;
			r_ridx <= ar_idx;
		end
	end

	assign o_rd_req.sel  = r_sel;
	assign o_rd_req.prot = r_prot;

	////////////////////////////////////////////////////////////////////////////
	// Data capture
	////////////////////////////////////////////////////////////////////////////

	// Index delayed to line up with the peripheral's answer
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_rwait)
			r_lidx <= r_ridx;
	end

	// Unmapped index reads as zero with DECERR
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_rvalid)
		begin
			if (slv_in_range(r_lidx))
			begin
				r_beat.data <= i_rdata_bus[r_lidx];
				r_beat.resp <= axil_resp_t'(i_rresp_bus[r_lidx]);
			end
			else
			begin
				r_beat.data <= '0;
				r_beat.resp <= DECERR;
			end
		end
	end

	assign o_push = r_push;
	assign o_r    = r_beat;

	// Read credits, up to the full R FIFO depth
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_count <= '0;
		else
		begin
			case ({ar_fire, i_rpop})
			2'b10: r_count <= r_count + 1'b1;
			2'b01: r_count <= r_count - 1'b1;
			default: r_count <= r_count;
			endcase
		end
	end

	// At most one peripheral strobed at a time
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(o_rd_req.sel));

	// Outstanding reads never exceed what the R FIFO can hold
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		r_count <= CW'(DEPTH));

endmodule

/* logic/resp_fifo.sv */
`timescale 1ns/1ps

module resp_fifo #(
	parameter type payload_t = logic [1:0],
	parameter int  LGFLEN    = 3
) (
	input  logic     S_AXI_ACLK,
	input  logic     S_AXI_ARESETN,
	input  logic     i_push,
	input  payload_t i_data,
	input  logic     i_pop,
	output payload_t o_data,
	output logic     o_empty
);

	localparam int DEPTH = 1 << LGFLEN;

	payload_t        mem [DEPTH];
	logic [LGFLEN:0] r_wr_ptr;
	logic [LGFLEN:0] r_rd_ptr;
	logic [LGFLEN:0] rd_next;
	logic            w_full;
	logic            w_pop;
	payload_t        r_data;

	// Extra pointer bit tells full from empty
	assign o_empty = (r_wr_ptr == r_rd_ptr);
	assign w_full  = (r_wr_ptr[LGFLEN] != r_rd_ptr[LGFLEN])
		&& (r_wr_ptr[LGFLEN-1:0] == r_rd_ptr[LGFLEN-1:0]);
	assign w_pop   = i_pop && !o_empty;
	assign rd_next = r_rd_ptr + 1'b1;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
		end
		else
		begin
			if (i_push)
				r_wr_ptr <= r_wr_ptr + 1'b1;
			if (w_pop)
				r_rd_ptr <= rd_next;
		end
	end

	// Storage
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_push)
			mem[r_wr_ptr[LGFLEN-1:0]] <= i_data;
	end

	// Head register
	// When the queue runs dry the incoming word goes straight to the head
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_empty || (w_pop && (rd_next == r_wr_ptr)))
		begin
			if (i_push)
				r_data <= i_data;
		end
		else if (w_pop)
			r_data <= mem[rd_next[LGFLEN-1:0]];
	end

	assign o_data = r_data;

	// Upstream credits must keep the queue from overflowing
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_push |-> !w_full);

endmodule

/* logic/write_path.sv */
`timescale 1ns/1ps
`include "axil_single_params.svh"

module write_path
	import axil_bus_pkg::*, axil_port_pkg::*;
(
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	// Address from the skid buffer
	input  logic          i_aw_valid,
	output logic          o_aw_ready,
	input  axil_addr_t    i_aw,
	// Host W channel
	input  logic          i_wvalid,
	output logic          o_wready,
	input  axil_wbeat_t   i_w,
	// B FIFO pop, returns a credit
	input  logic          i_bpop,
	// Peripheral side
	output slv_wr_req_t   o_wr_req,
	input  slv_resp_bus_t i_bresp_bus,
	// B FIFO push
	output logic          o_push,
	output axil_resp_t    o_bresp
);

	localparam int DEPTH = 1 << `AXIL_LGFLEN;
	localparam int CW    = `AXIL_LGFLEN + 1;

	logic          r_wready;
	slv_sel_t      r_sel;
	logic [2:0]    r_prot;
	slv_idx_t      r_widx;
	logic          r_bwait;
	slv_idx_t      r_bidx;
	logic          r_push;
	axil_resp_t    r_bresp;
	logic [CW-1:0] r_count;
	logic          w_full;
	logic          aw_fire;
	logic          w_fire;
	slv_idx_t      aw_idx;

	////////////////////////////////////////////////////////////////////////////
	// Address accept and write strobe
	////////////////////////////////////////////////////////////////////////////

	assign aw_idx = slv_index(i_aw);

	// Skid buffer holds one more, so stop one short of the FIFO depth
	assign w_full = (r_count == CW'(DEPTH - 1));

	// Next address only once the current data beat is in
	assign o_aw_ready = (!r_wready || i_wvalid) && !w_full;
	assign aw_fire    = i_aw_valid && o_aw_ready;
	assign w_fire     = i_wvalid && r_wready;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_wready <= 1'b0;
			r_sel    <= '0;
		end
		else if (aw_fire)
		begin
			r_wready <= 1'b1;
			r_sel    <= slv_decode(aw_idx);
		end
		else if (i_wvalid)
		begin
			r_wready <= 1'b0;
			r_sel    <= '0;
		end
	end

	// Index and prot of the write waiting for its data
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_fire)
		begin
			r_prot <= i_aw.prot;
			r_widx <= aw_idx;
		end
	end

	assign o_wready = r_wready;

	// Strobe fires on the W beat itself, data goes to everyone
	assign o_wr_req.sel  = i_wvalid ? r_sel : '0;
	assign o_wr_req.prot = r_prot;
	assign o_wr_req.w    = i_w;

	////////////////////////////////////////////////////////////////////////////
	// Response capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			r_bwait <= 1'b0;
			r_push  <= 1'b0;
		end
		else
		begin
			r_bwait <= w_fire;
			r_push  <= r_bwait;
		end
	end

	// Second index stage, follows the beat into the response cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (w_fire)
			r_bidx <= r_widx;
	end

	// Peripheral answers the cycle after its strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (r_bwait)
		begin
			if (slv_in_range(r_bidx))
				r_bresp <= axil_resp_t'(i_bresp_bus[r_bidx]);
			else
				r_bresp <= DECERR;
		end
	end

	assign o_push  = r_push;
	assign o_bresp = r_bresp;

	// Write credits, one per accepted address until its B pops
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_count <= '0;
		else
		begin
			case ({aw_fire, i_bpop})
			2'b10: r_count <= r_count + 1'b1;
			2'b01: r_count <= r_count - 1'b1;
			default: r_count <= r_count;
			endcase
		end
	end

	// At most one peripheral strobed at a time
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(o_wr_req.sel));

	// Outstanding writes never exceed what the B FIFO can hold
	assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		r_count <= CW'(DEPTH));

endmodule

/* sim/tb_axil_single.sv */
`timescale 1ns/1ps
`include "axil_single_params.svh"

module tb_axil_single
	import axil_bus_pkg::*, axil_port_pkg::*;
();

	localparam int          NS    = `AXIL_NS;
	localparam int          DEPTH = 1 << `AXIL_LGFLEN;
	localparam logic [31:0] SEED  = 32'hdbf1193c;

	// One transaction with its expected answer
	typedef struct packed
	{
		logic                is_wr;
		slv_idx_t            idx;
		logic [`AXIL_DW-1:0] data;
		logic [3:0]          strb;
		axil_resp_t          exp_resp;
		logic [`AXIL_DW-1:0] exp_data;
	} op_t;

	logic        S_AXI_ACLK = 1'b0;
	logic        S_AXI_ARESETN;
	logic        awvalid;
	logic        awready;
	axil_addr_t  aw;
	logic        wvalid;
	logic        wready;
	axil_wbeat_t w;
	logic        bvalid;
	logic        bready;
	axil_resp_t  bresp;
	logic        arvalid;
	logic        arready;
	axil_addr_t  ar;
	logic        rvalid;
	logic        rready;
	axil_rbeat_t rbeat;
	slv_wr_req_t wr_req;
	slv_rd_req_t rd_req;
	slv_rsp_t    rsp;

	// Traffic engine state
	op_t                 ops [$];
	axil_resp_t          exp_b [$];
	axil_rbeat_t         exp_r [$];
	logic [`AXIL_DW-1:0] ref_regs [NS];
	logic                aw_hs;
	logic                w_hs;
	logic                ar_hs;
	logic                strobe_seen;
	// Prot of the last accepted read, its strobe follows one cycle later
	logic [2:0]          ar_prot;
	// Ready mode 0 holds low, 1 holds high and 2 adds random gaps
	logic [1:0]          b_mode;
	logic [1:0]          r_mode;
	logic [31:0]         lfsr;
	int                  aw_count;
	int                  ar_count;
	int                  n_checks;
	int                  n_errors;

	// Directed cases with partial strobes and then unmapped indices 12 to 15
	op_t dir_table [13] = '{
		'{1'b1, 4'd3,  32'h11223344, 4'hf, SLVERR, 32'h0},
		'{1'b0, 4'd3,  32'h0,        4'h0, OKAY,   32'h11223344},
		'{1'b1, 4'd3,  32'haabbccdd, 4'h5, SLVERR, 32'h0},
		'{1'b0, 4'd3,  32'h0,        4'h0, OKAY,   32'h11bb33dd},
		'{1'b1, 4'd6,  32'hcafef00d, 4'hf, OKAY,   32'h0},
		'{1'b1, 4'd6,  32'h00005500, 4'h2, OKAY,   32'h0},
		'{1'b0, 4'd6,  32'h0,        4'h0, OKAY,   32'hcafe550d},
		'{1'b1, 4'd12, 32'hdeadbeef, 4'hf, DECERR, 32'h0},
		'{1'b0, 4'd12, 32'h0,        4'h0, DECERR, 32'h0},
		'{1'b1, 4'd15, 32'h01234567, 4'h3, DECERR, 32'h0},
		'{1'b0, 4'd13, 32'h0,        4'h0, DECERR, 32'h0},
		'{1'b1, 4'd14, 32'h89abcdef, 4'hf, DECERR, 32'h0},
		'{1'b0, 4'd15, 32'h0,        4'h0, DECERR, 32'h0}
	};

	always #2 S_AXI_ACLK = ~S_AXI_ACLK;

	axil_single_top u_dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (awvalid),
		.o_awready     (awready),
		.i_aw          (aw),
		.i_wvalid      (wvalid),
		.o_wready      (wready),
		.i_w           (w),
		.o_bvalid      (bvalid),
		.i_bready      (bready),
		.o_bresp       (bresp),
		.i_arvalid     (arvalid),
		.o_arready     (arready),
		.i_ar          (ar),
		.o_rvalid      (rvalid),
		.i_rready      (rready),
		.o_r           (rbeat),
		.o_wr_req      (wr_req),
		.o_rd_req      (rd_req),
		.i_rsp         (rsp)
	);

	tb_periph_bank u_bank (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr_req      (wr_req),
		.i_rd_req      (rd_req),
		.o_rsp         (rsp)
	);

	////////////////////////////////////////////////////////////////////////////
	// Checks and reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_rbeat(input string name, input axil_rbeat_t got, input axil_rbeat_t exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED %s: got data 0x%h resp 0x%0h expected data 0x%h resp 0x%0h",
				name, got.data, got.resp, exp.data, exp.resp);
		end
	endtask

	task automatic check_prot(input string name, input logic [2:0] got, input logic [2:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		n_checks++;
		if (got != exp)
		begin
			n_errors++;
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic report_error(input string what);
		n_errors++;
		$display("ERROR: %s", what);
	endtask

	task automatic end_test(input string name, input int mark);
		$display("Test %s finished with %0d errors", name, n_errors - mark);
	endtask

	// Give up at once on a stuck wait
	task automatic timeout(input string what);
		n_errors++;
		$display("Timeout while waiting for %s", what);
		$display("Checks failed");
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic pick_ready(input logic [1:0] mode);
		if (mode == 2'd2)
			return (rand_bits(2) != 32'd0);
		return (mode == 2'd1);
	endfunction

	// Expected answer from the bridge rules and the reference registers
	function automatic op_t predict(input logic is_wr, input slv_idx_t idx,
		input logic [31:0] data, input logic [3:0] strb);
		op_t r;
		r.is_wr    = is_wr;
		r.idx      = idx;
		r.data     = data;
		r.strb     = strb;
		r.exp_data = '0;
		if (idx >= NS)
			r.exp_resp = DECERR;
		else if (is_wr)
			r.exp_resp = idx[0] ? SLVERR : OKAY;
		else
		begin
			r.exp_resp = OKAY;
			r.exp_data = ref_regs[idx];
		end
		return r;
	endfunction

	// Queue in issue order and update the reference with each write at once
	task automatic queue_op(input op_t r);
		axil_rbeat_t beat;
		ops.push_back(r);
		if (r.is_wr)
		begin
			exp_b.push_back(r.exp_resp);
			if (r.idx < NS)
			begin
				for (int b = 0; b < 4; b++)
				begin
					if (r.strb[b])
						ref_regs[r.idx][8*b +: 8] = r.data[8*b +: 8];
				end
			end
		end
		else
		begin
			beat.data = r.exp_data;
			beat.resp = r.exp_resp;
			exp_r.push_back(beat);
		end
	endtask

	// One clock of traffic
	// Drive on the falling edge and sample 1 ns later while everything is settled
	task automatic step_cycle();
		op_t cur;
		@(negedge S_AXI_ACLK);
		if (aw_hs)
			awvalid = 1'b0;
		if (w_hs)
			wvalid = 1'b0;
		if (ar_hs)
			arvalid = 1'b0;
		// Next request only once the last one is fully accepted
		if (!awvalid && !wvalid && !arvalid && ops.size() > 0)
		begin
			cur = ops.pop_front();
			if (cur.is_wr)
			begin
				aw.addr = {cur.idx, {`AXIL_ADDR_LSBS{1'b0}}};
				aw.prot = 3'(rand_bits(3));
				w.data  = cur.data;
				w.strb  = cur.strb;
				awvalid = 1'b1;
				wvalid  = 1'b1;
			end
			else
			begin
				ar.addr = {cur.idx, {`AXIL_ADDR_LSBS{1'b0}}};
				ar.prot = 3'(rand_bits(3));
				arvalid = 1'b1;
			end
		end
		bready = pick_ready(b_mode);
		rready = pick_ready(r_mode);
		#1;
		if (wr_req.sel != '0 || rd_req.sel != '0)
			strobe_seen = 1'b1;
		// Prot travels with every strobe
		if (wr_req.sel != '0)
			check_prot("o_wr_req.prot", wr_req.prot, aw.prot);
		if (rd_req.sel != '0)
			check_prot("o_rd_req.prot", rd_req.prot, ar_prot);
		aw_hs = awvalid && awready;
		w_hs  = wvalid && wready;
		ar_hs = arvalid && arready;
		if (aw_hs)
			aw_count++;
		if (ar_hs)
		begin
			ar_count++;
			ar_prot = ar.prot;
		end
		if (bvalid && bready)
		begin
			if (exp_b.size() == 0)
				report_error("write response with no write outstanding");
			else
				check_resp("o_bresp", bresp, exp_b.pop_front());
		end
		if (rvalid && rready)
		begin
			if (exp_r.size() == 0)
				report_error("read response with no read outstanding");
			else
				check_rbeat("o_r", rbeat, exp_r.pop_front());
		end
	endtask

	function automatic logic traffic_idle();
		return ops.size() == 0 && !awvalid && !wvalid && !arvalid
			&& exp_b.size() == 0 && exp_r.size() == 0;
	endfunction

	// Run until every queued transaction has its response
	task automatic drain(input string what, input int limit);
		int n;
		n = 0;
		while (!traffic_idle() && n < limit)
		begin
			step_cycle();
			n++;
		end
		if (!traffic_idle())
			timeout(what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int mark;
		int n;
		logic is_wr;
		S_AXI_ARESETN = 1'b0;
		awvalid = 1'b0;
		aw      = '0;
		wvalid  = 1'b0;
		w       = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		ar      = '0;
		rready  = 1'b0;
		aw_hs = 1'b0;
		w_hs  = 1'b0;
		ar_hs = 1'b0;
		strobe_seen = 1'b0;
		ar_prot = 3'b000;
		b_mode = 2'd1;
		r_mode = 2'd1;
		lfsr   = SEED;
		aw_count = 0;
		ar_count = 0;
		n_checks = 0;
		n_errors = 0;
		for (int k = 0; k < NS; k++)
			ref_regs[k] = '0;

		repeat (4) @(posedge S_AXI_ACLK);
		@(negedge S_AXI_ACLK);
		S_AXI_ARESETN = 1'b1;
		#1;

		// Idle levels straight out of reset
		mark = n_errors;
		check_level("o_bvalid", bvalid, 1'b0);
		check_level("o_rvalid", rvalid, 1'b0);
		check_level("o_wready", wready, 1'b0);
		check_level("o_awready", awready, 1'b1);
		check_level("o_arready", arready, 1'b1);
		end_test("reset", mark);

		// Full word to every peripheral and then read back
		mark = n_errors;
		for (int k = 0; k < NS; k++)
		begin
			queue_op(predict(1'b1, slv_idx_t'(k), rand_bits(32), 4'hf));
			queue_op(predict(1'b0, slv_idx_t'(k), 32'h0, 4'h0));
		end
		drain("write and read back", 2000);
		end_test("write and read back", mark);

		// Directed table one row at a time so strobes can be pinned on it
		mark = n_errors;
		for (int i = 0; i < $size(dir_table); i++)
		begin
			strobe_seen = 1'b0;
			queue_op(dir_table[i]);
			drain("directed table row", 200);
			if (dir_table[i].idx >= NS && strobe_seen)
				report_error($sformatf("peripheral strobe raised for unmapped index %0d",
					dir_table[i].idx));
		end
		end_test("directed table", mark);

		// With B held off the address channel must stall at the FIFO depth
		mark = n_errors;
		b_mode = 2'd0;
		aw_count = 0;
		for (int k = 0; k < DEPTH + 2; k++)
			queue_op(predict(1'b1, slv_idx_t'(k), rand_bits(32), 4'hf));
		n = 0;
		while (awready && n < 200)
		begin
			step_cycle();
			n++;
		end
		if (awready)
			report_error("write address channel never stalled with B held off");
		check_count("write addresses accepted", aw_count, DEPTH);
		b_mode = 2'd1;
		drain("write back-pressure release", 1000);
		end_test("write back-pressure", mark);

		// Same for reads with R held off
		mark = n_errors;
		r_mode = 2'd0;
		ar_count = 0;
		for (int k = 0; k < DEPTH + 2; k++)
			queue_op(predict(1'b0, slv_idx_t'(k), 32'h0, 4'h0));
		n = 0;
		while (arready && n < 200)
		begin
			step_cycle();
			n++;
		end
		if (arready)
			report_error("read address channel never stalled with R held off");
		check_count("read addresses accepted", ar_count, DEPTH);
		r_mode = 2'd1;
		drain("read back-pressure release", 1000);
		end_test("read back-pressure", mark);

		// Mixed traffic over the whole index range with random ready gaps
		mark = n_errors;
		b_mode = 2'd2;
		r_mode = 2'd2;
		for (int i = 0; i < 80; i++)
		begin
			is_wr = 1'(rand_bits(1));
			if (is_wr)
				queue_op(predict(1'b1, slv_idx_t'(rand_bits(4)), rand_bits(32),
					4'(rand_bits(4))));
			else
				queue_op(predict(1'b0, slv_idx_t'(rand_bits(4)), 32'h0, 4'h0));
		end
		drain("random traffic", 8000);
		end_test("random traffic", mark);

		$display("Summary: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* sim/tb_periph_bank.sv */
`timescale 1ns/1ps
`include "axil_single_params.svh"

module tb_periph_bank
	import axil_bus_pkg::*, axil_port_pkg::*;
(
	input  logic        S_AXI_ACLK,
	input  logic        S_AXI_ARESETN,
	input  slv_wr_req_t i_wr_req,
	input  slv_rd_req_t i_rd_req,
	output slv_rsp_t    o_rsp
);

	// One word per peripheral
	logic [`AXIL_DW-1:0] regs [`AXIL_NS];

	// Every peripheral answers on the cycle after its strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int k = 0; k < `AXIL_NS; k++)
				regs[k] <= '0;
			o_rsp <= '0;
		end
		else
		begin
			for (int k = 0; k < `AXIL_NS; k++)
			begin
				// Byte-masked write, odd peripherals flag SLVERR
				if (i_wr_req.sel[k])
				begin
					for (int b = 0; b < `AXIL_DW/8; b++)
					begin
						if (i_wr_req.w.strb[b])
							regs[k][8*b +: 8] <= i_wr_req.w.data[8*b +: 8];
					end
					o_rsp.bresp[k] <= (k % 2 == 1) ? SLVERR : OKAY;
				end
				// Read returns the word as it was before this edge
				if (i_rd_req.sel[k])
				begin
					o_rsp.rdata[k] <= regs[k];
					o_rsp.rresp[k] <= OKAY;
				end
			end
		end
	end

endmodule
